// ==== source/creator_config.svh ====
`ifndef CREATOR_CONFIG_SVH
`define CREATOR_CONFIG_SVH

// --------------------------------------------------
// Bus geometry
// --------------------------------------------------
`define CR_ADDR_WIDTH         15
`define CR_DATA_WIDTH         16
// One select bit per byte lane
`define CR_SEL_WIDTH          2
// Top address bits pick the slave slot
`define CR_SLOT_BITS          3

// --------------------------------------------------
// Configuration block constants
// --------------------------------------------------
`define CR_VERSION            64'h44E8_05C3_000A_0001
`define CR_CLKFX_DIVIDE       1
`define CR_CLKFX_MULTIPLY     3
// Mic sample-rate and gain register defaults
`define CR_DECIMATION_DEFAULT 2
`define CR_GAIN_DEFAULT       3

// --------------------------------------------------
// Peripheral sizes
// --------------------------------------------------
`define CR_GPIO_WIDTH         16
// Scratch RAM holds 2**8 words
`define CR_SCRATCH_ADDR_BITS  8

`endif

// ==== source/bus_pkg.sv ====
`include "creator_config.svh"

package bus_pkg;

  // --------------------------------------------------
  // Word, address and lane types of the host bus
  // --------------------------------------------------
  typedef logic [`CR_DATA_WIDTH-1:0] bus_word_t;
  typedef logic [`CR_ADDR_WIDTH-1:0] bus_addr_t;
  // Byte lane enables, bit 0 is the low byte
  typedef logic [`CR_SEL_WIDTH-1:0]  bus_sel_t;

  // --------------------------------------------------
  // Slave slots
  // --------------------------------------------------
  // Slot is taken from the top address bits
  // 0x0000 config, 0x4000 gpio, 0x5000 scratch
  // Values 1, 2, 3, 6, 7 are left unmapped
  typedef enum logic [`CR_SLOT_BITS-1:0] {
    SLOT_CONFIG  = 3'd0,
    SLOT_GPIO    = 3'd4,
    SLOT_SCRATCH = 3'd5
  } slave_slot_e;

  // Word offset width inside one slot
  localparam int unsigned OFF_BITS = `CR_ADDR_WIDTH - `CR_SLOT_BITS;

endpackage

// ==== source/periph_pkg.sv ====
package periph_pkg;

  // --------------------------------------------------
  // Configuration block word offsets
  // --------------------------------------------------
  // Version words, least significant word first
  // Clock word packs divide in the high byte
  typedef enum logic [2:0] {
    CFG_VERSION0    = 3'd0,
    CFG_VERSION1    = 3'd1,
    CFG_VERSION2    = 3'd2,
    CFG_VERSION3    = 3'd3,
    CFG_CLKFX       = 3'd4,
    // Writable mic settings
    CFG_SAMPLE_RATE = 3'd5,
    CFG_GAIN        = 3'd6
  } cfg_reg_e;

  // --------------------------------------------------
  // GPIO block word offsets
  // --------------------------------------------------
  // Direction bit set means pin is driven
  typedef enum logic [1:0] {
    GPIO_DIR = 2'd0,
    GPIO_OUT = 2'd1,
    // Read-only synchronized pin state
    GPIO_IN  = 2'd2
  } gpio_reg_e;

endpackage

// ==== source/wb_decoder.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module wb_decoder import bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  // Host side
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_sel_t  sel_i,
  input  bus_addr_t adr_i,
  input  bus_word_t dat_i,
  output bus_word_t dat_o,
  output logic      ack_o,
  // Shared request lines to the slaves
  output logic      slv_we_o,
  output bus_sel_t  slv_sel_o,
  output bus_addr_t slv_off_o,
  output bus_word_t slv_dat_o,
  // Per-slot strobes
  output logic      cfg_stb_o,
  output logic      gpio_stb_o,
  output logic      ram_stb_o,
  // Per-slot returns
  input  bus_word_t cfg_dat_i,
  input  logic      cfg_ack_i,
  input  bus_word_t gpio_dat_i,
  input  logic      gpio_ack_i,
  input  bus_word_t ram_dat_i,
  input  logic      ram_ack_i
);

  slave_slot_e slot;
  logic        unm_req;
  logic        unm_ack_q;

  // --------------------------------------------------
  // Slot decode
  // --------------------------------------------------
  assign slot = slave_slot_e'(adr_i[`CR_ADDR_WIDTH-1 -: `CR_SLOT_BITS]);

  always_comb begin
    cfg_stb_o  = 1'b0;
    gpio_stb_o = 1'b0;
    ram_stb_o  = 1'b0;
    unm_req    = 1'b0;
    // Only a live cycle reaches a slave
    if (cyc_i && stb_i) begin
      case (slot)
        SLOT_CONFIG:  cfg_stb_o  = 1'b1;
        SLOT_GPIO:    gpio_stb_o = 1'b1;
        SLOT_SCRATCH: ram_stb_o  = 1'b1;
        // Slots 1, 2, 3, 6 and 7
        default:      unm_req    = 1'b1;
      endcase
    end
  end

  // Request fields go to every slave, the strobe picks one
  assign slv_we_o  = we_i;
  assign slv_sel_o = sel_i;
  assign slv_dat_o = dat_i;
  // Slot bits stripped, offset is relative to the slot base
  assign slv_off_o = {{`CR_SLOT_BITS{1'b0}}, adr_i[OFF_BITS-1:0]};

  // --------------------------------------------------
  // Unmapped-slot responder
  // --------------------------------------------------
  // Same one-cycle pulse as a real slave, no re-ack
  always_ff @(posedge clk) begin
    if (reset_i) begin
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= unm_req && !unm_ack_q;
    end
  end

  // --------------------------------------------------
  // Return path
  // --------------------------------------------------
  assign ack_o = cfg_ack_i | gpio_ack_i | ram_ack_i | unm_ack_q;

  // Data from whichever source acks, zero otherwise
  always_comb begin
    if (cfg_ack_i) begin
      dat_o = cfg_dat_i;
    end else if (gpio_ack_i) begin
      dat_o = gpio_dat_i;
    end else if (ram_ack_i) begin
      dat_o = ram_dat_i;
    end else begin
      dat_o = '0;
    end
  end

  // Slaves and responder never answer together
  a_one_ack: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({cfg_ack_i, gpio_ack_i, ram_ack_i, unm_ack_q}));

endmodule

// ==== source/config_regs.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module config_regs import bus_pkg::*; import periph_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  // Slot request
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t off_i,
  input  bus_word_t dat_i,
  output bus_word_t dat_o,
  output logic      ack_o,
  // Mic settings out of the top level
  output bus_word_t sample_rate_o,
  output bus_word_t gain_o
);

  localparam logic [63:0] VERSION = `CR_VERSION;
  // Divide in the high byte, multiply in the low byte
  localparam bus_word_t CLKFX_WORD = {8'(`CR_CLKFX_DIVIDE), 8'(`CR_CLKFX_MULTIPLY)};

  cfg_reg_e  reg_sel;
  logic      in_map;
  logic      access;
  bus_word_t rd_word;

  // --------------------------------------------------
  // Offset decode
  // --------------------------------------------------
  assign reg_sel = cfg_reg_e'(off_i[2:0]);
  // Anything past the gain word reads zero
  assign in_map  = (off_i <= bus_addr_t'(CFG_GAIN));
  // First cycle of a strobe only
  assign access  = stb_i && !ack_o;

  always_comb begin
    rd_word = '0;
    if (in_map) begin
      case (reg_sel)
        CFG_VERSION0:    rd_word = VERSION[15:0];
        CFG_VERSION1:    rd_word = VERSION[31:16];
        CFG_VERSION2:    rd_word = VERSION[47:32];
        CFG_VERSION3:    rd_word = VERSION[63:48];
        CFG_CLKFX:       rd_word = CLKFX_WORD;
        CFG_SAMPLE_RATE: rd_word = sample_rate_o;
        CFG_GAIN:        rd_word = gain_o;
        default:         rd_word = '0;
      endcase
    end
  end

  // --------------------------------------------------
  // Handshake and writable registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_o         <= 1'b0;
      sample_rate_o <= bus_word_t'(`CR_DECIMATION_DEFAULT);
      gain_o        <= bus_word_t'(`CR_GAIN_DEFAULT);
    end else begin
      ack_o <= access;
      // Version and clock words ignore writes
      if (access && we_i && in_map) begin
        if (reg_sel == CFG_SAMPLE_RATE) begin
          sample_rate_o <= dat_i;
        end
        if (reg_sel == CFG_GAIN) begin
          gain_o <= dat_i;
        end
      end
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= rd_word;
    end
  end

  // Ack stays a single-cycle pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (reset_i)
    ack_o |=> !ack_o);

endmodule

// ==== source/gpio_port.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module gpio_port import bus_pkg::*; import periph_pkg::*; (
  input  logic                     clk,
  input  logic                     reset_i,
  // Slot request
  input  logic                     stb_i,
  input  logic                     we_i,
  input  bus_addr_t                off_i,
  input  bus_word_t                dat_i,
  output bus_word_t                dat_o,
  output logic                     ack_o,
  // Pins, split in/out/enable
  input  logic [`CR_GPIO_WIDTH-1:0] pin_i,
  output logic [`CR_GPIO_WIDTH-1:0] pin_o,
  output logic [`CR_GPIO_WIDTH-1:0] oe_o
);

  logic [`CR_GPIO_WIDTH-1:0] dir_q;
  logic [`CR_GPIO_WIDTH-1:0] out_q;
  logic [`CR_GPIO_WIDTH-1:0] sync_meta_q;
  logic [`CR_GPIO_WIDTH-1:0] sync_q;
  gpio_reg_e                 reg_sel;
  logic                      in_map;
  logic                      access;
  bus_word_t                 rd_word;

  assign reg_sel = gpio_reg_e'(off_i[1:0]);
  // Offset 3 and up is empty
  assign in_map  = (off_i <= bus_addr_t'(GPIO_IN));
  assign access  = stb_i && !ack_o;

  // --------------------------------------------------
  // Pin input synchronizer
  // --------------------------------------------------
  // Two flops, pin change visible after two edges
  always_ff @(posedge clk) begin
    sync_meta_q <= pin_i;
    sync_q      <= sync_meta_q;
  end

  always_comb begin
    rd_word = '0;
    if (in_map) begin
      case (reg_sel)
        GPIO_DIR: rd_word = dir_q;
        GPIO_OUT: rd_word = out_q;
        GPIO_IN:  rd_word = sync_q;
        default:  rd_word = '0;
      endcase
    end
  end

  // --------------------------------------------------
  // Registers and handshake
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_o <= 1'b0;
      dir_q <= '0;
      out_q <= '0;
    end else begin
      ack_o <= access;
      // GPIO_IN is read-only
      if (access && we_i && in_map && reg_sel == GPIO_DIR) begin
        dir_q <= dat_i;
      end
      if (access && we_i && in_map && reg_sel == GPIO_OUT) begin
        out_q <= dat_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= rd_word;
    end
  end

  assign pin_o = out_q;
  assign oe_o  = dir_q;

  // All pins released right after reset
  a_oe_reset: assert property (@(posedge clk) reset_i |=> (oe_o == '0));

endmodule

// ==== source/scratch_bram.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module scratch_bram import bus_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  // Slot request
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_sel_t  sel_i,
  input  bus_addr_t off_i,
  input  bus_word_t dat_i,
  output bus_word_t dat_o,
  output logic      ack_o
);

  localparam int unsigned DEPTH = 2 ** `CR_SCRATCH_ADDR_BITS;

  bus_word_t                        mem [DEPTH];
  logic [`CR_SCRATCH_ADDR_BITS-1:0] idx;
  logic                             access;

  // Low offset bits only, upper bits alias
  assign idx    = off_i[`CR_SCRATCH_ADDR_BITS-1:0];
  assign access = stb_i && !ack_o;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  // Read-before-write, old word comes back on a write
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= mem[idx];
      if (we_i) begin
        for (int lane = 0; lane < `CR_SEL_WIDTH; lane++) begin
          // Untouched lanes keep their byte
          if (sel_i[lane]) begin
            mem[idx][lane*8 +: 8] <= dat_i[lane*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== source/creator_system.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module creator_system import bus_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_i,
  // Host bus
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  bus_sel_t                  sel_i,
  input  bus_addr_t                 adr_i,
  input  bus_word_t                 dat_i,
  output bus_word_t                 dat_o,
  output logic                      ack_o,
  // GPIO pins
  input  logic [`CR_GPIO_WIDTH-1:0] gpio_in_i,
  output logic [`CR_GPIO_WIDTH-1:0] gpio_out_o,
  output logic [`CR_GPIO_WIDTH-1:0] gpio_oe_o,
  // Mic settings
  output bus_word_t                 mic_sample_rate_o,
  output bus_word_t                 mic_data_gain_o
);

  logic      slv_we;
  bus_sel_t  slv_sel;
  bus_addr_t slv_off;
  bus_word_t slv_dat;
  logic      cfg_stb, gpio_stb, ram_stb;
  logic      cfg_ack, gpio_ack, ram_ack;
  bus_word_t cfg_dat, gpio_dat, ram_dat;

  // --------------------------------------------------
  // Interconnect
  // --------------------------------------------------
  wb_decoder decoder_i (
    .clk(clk), .reset_i(reset_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .sel_i(sel_i),
    .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
    .slv_we_o(slv_we), .slv_sel_o(slv_sel), .slv_off_o(slv_off), .slv_dat_o(slv_dat),
    .cfg_stb_o(cfg_stb), .gpio_stb_o(gpio_stb), .ram_stb_o(ram_stb),
    .cfg_dat_i(cfg_dat), .cfg_ack_i(cfg_ack),
    .gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack),
    .ram_dat_i(ram_dat), .ram_ack_i(ram_ack)
  );

  // Slot 0, version and mic settings
  config_regs config_i (
    .clk(clk), .reset_i(reset_i),
    .stb_i(cfg_stb), .we_i(slv_we), .off_i(slv_off), .dat_i(slv_dat),
    .dat_o(cfg_dat), .ack_o(cfg_ack),
    .sample_rate_o(mic_sample_rate_o), .gain_o(mic_data_gain_o)
  );

  // Slot 4
  gpio_port gpio_i (
    .clk(clk), .reset_i(reset_i),
    .stb_i(gpio_stb), .we_i(slv_we), .off_i(slv_off), .dat_i(slv_dat),
    .dat_o(gpio_dat), .ack_o(gpio_ack),
    .pin_i(gpio_in_i), .pin_o(gpio_out_o), .oe_o(gpio_oe_o)
  );

  // Slot 5, only slave using byte lanes
  scratch_bram scratch_i (
    .clk(clk), .reset_i(reset_i),
    .stb_i(ram_stb), .we_i(slv_we), .sel_i(slv_sel), .off_i(slv_off), .dat_i(slv_dat),
    .dat_o(ram_dat), .ack_o(ram_ack)
  );

endmodule

// ==== dv/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------------------------------------
// Shadow state of the register map
// --------------------------------------------------
localparam int SCRATCH_DEPTH     = 1 << `CR_SCRATCH_ADDR_BITS;
localparam int MIC_ROUNDS        = 40;
localparam int SCRATCH_WRITES    = 300;
localparam int GPIO_ROUNDS       = 10;
localparam int UNMAPPED_ACCESSES = 20;

bus_word_t  scratch_mem   [SCRATCH_DEPTH];
// Byte lanes written at least once, RAM has no reset
logic [1:0] scratch_known [SCRATCH_DEPTH];
bus_word_t  model_rate;
bus_word_t  model_gain;
bus_word_t  model_dir;
bus_word_t  model_out;

task automatic init_model();
  for (int i = 0; i < SCRATCH_DEPTH; i++) begin
    scratch_mem[i]   = '0;
    scratch_known[i] = 2'b00;
  end
  model_rate = bus_word_t'(`CR_DECIMATION_DEFAULT);
  model_gain = bus_word_t'(`CR_GAIN_DEFAULT);
  model_dir  = '0;
  model_out  = '0;
endtask

// Slot in the top three bits, word offset below
function automatic bus_addr_t slot_address(input logic [2:0] slot, input logic [11:0] off);
  return {slot, off};
endfunction

// Slots 1, 2, 3, 6 and 7 have no slave
function automatic logic [2:0] unmapped_slot(input logic [2:0] pick);
  case (pick)
    3'd0:    return 3'd1;
    3'd1:    return 3'd2;
    3'd2:    return 3'd3;
    3'd3:    return 3'd6;
    default: return 3'd7;
  endcase
endfunction

// Config block read value for one word offset
function automatic bus_word_t expected_config_word(input logic [11:0] off);
  logic [63:0] version;
  version = `CR_VERSION;
  case (off)
    12'(CFG_VERSION0):    return version[15:0];
    12'(CFG_VERSION1):    return version[31:16];
    12'(CFG_VERSION2):    return version[47:32];
    12'(CFG_VERSION3):    return version[63:48];
    // Divide in high byte, multiply in low byte
    12'(CFG_CLKFX):       return {8'(`CR_CLKFX_DIVIDE), 8'(`CR_CLKFX_MULTIPLY)};
    12'(CFG_SAMPLE_RATE): return model_rate;
    12'(CFG_GAIN):        return model_gain;
    default:              return '0;
  endcase
endfunction

function automatic bus_word_t merge_lanes(input bus_word_t old_word, input bus_word_t new_word,
                                          input bus_sel_t sel);
  bus_word_t result;
  result = old_word;
  if (sel[0]) begin
    result[7:0] = new_word[7:0];
  end
  if (sel[1]) begin
    result[15:8] = new_word[15:8];
  end
  return result;
endfunction

// Only bytes with a known value are compared
function automatic bus_word_t known_mask(input logic [1:0] known);
  return {{8{known[1]}}, {8{known[0]}}};
endfunction

// --------------------------------------------------
// Test sequences
// --------------------------------------------------
task automatic verify_reset_state();
  bus_word_t rd;
  check_equal("ack_o", bus_word_t'(ack_o), 16'd0);
  check_equal("gpio_oe_o", gpio_oe_o, 16'd0);
  check_equal("gpio_out_o", gpio_out_o, 16'd0);
  check_equal("mic_sample_rate_o", mic_sample_rate_o, model_rate);
  check_equal("mic_data_gain_o", mic_data_gain_o, model_gain);
  // Whole config block including the empty offset 7
  for (int off = 0; off < 8; off++) begin
    bus_access(1'b0, 2'b11, slot_address(SLOT_CONFIG, 12'(off)), '0, rd);
    check_equal("config read", rd, expected_config_word(12'(off)));
  end
endtask

task automatic mic_settings_sequence();
  bus_word_t   w;
  bus_word_t   data;
  bus_word_t   rd;
  logic [11:0] off;
  for (int i = 0; i < MIC_ROUNDS; i++) begin
    w    = random_word();
    data = random_word();
    // Mostly mapped offsets, now and then a far one
    off  = (w[15:13] == 3'd0) ? w[11:0] : {9'd0, w[2:0]};
    bus_access(1'b1, 2'b11, slot_address(SLOT_CONFIG, off), data, rd);
    if (off == 12'(CFG_SAMPLE_RATE)) begin
      model_rate = data;
    end
    if (off == 12'(CFG_GAIN)) begin
      model_gain = data;
    end
    check_equal("mic_sample_rate_o", mic_sample_rate_o, model_rate);
    check_equal("mic_data_gain_o", mic_data_gain_o, model_gain);
    bus_access(1'b0, 2'b11, slot_address(SLOT_CONFIG, off), '0, rd);
    check_equal("config read", rd, expected_config_word(off));
  end
endtask

task automatic scratch_ram_sequence();
  bus_word_t   w;
  bus_word_t   w2;
  bus_word_t   data;
  bus_word_t   rd;
  bus_word_t   mask;
  logic [11:0] off;
  logic [11:0] rd_off;
  logic [7:0]  idx;
  for (int i = 0; i < SCRATCH_WRITES; i++) begin
    w    = random_word();
    w2   = random_word();
    data = random_word();
    off  = w[11:0];
    idx  = off[7:0];
    bus_access(1'b1, w[13:12], slot_address(SLOT_SCRATCH, off), data, rd);
    // Write returns the word held before it
    mask = known_mask(scratch_known[idx]);
    check_equal("scratch old word", rd & mask, scratch_mem[idx] & mask);
    scratch_mem[idx]   = merge_lanes(scratch_mem[idx], data, w[13:12]);
    scratch_known[idx] = scratch_known[idx] | w[13:12];
    // Alias of the same word, or any word
    rd_off = w[14] ? {w2[3:0], idx} : w2[11:0];
    bus_access(1'b0, 2'b00, slot_address(SLOT_SCRATCH, rd_off), '0, rd);
    mask = known_mask(scratch_known[rd_off[7:0]]);
    check_equal("scratch read", rd & mask, scratch_mem[rd_off[7:0]] & mask);
  end
endtask

task automatic gpio_sequence();
  bus_word_t pins;
  bus_word_t rd;
  for (int i = 0; i < GPIO_ROUNDS; i++) begin
    model_dir = random_word();
    model_out = random_word();
    pins      = random_word();
    bus_access(1'b1, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_DIR)), model_dir, rd);
    bus_access(1'b1, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_OUT)), model_out, rd);
    check_equal("gpio_oe_o", gpio_oe_o, model_dir);
    check_equal("gpio_out_o", gpio_out_o, model_out);
    // Pins held long enough to cross the synchronizer
    gpio_in_i = pins;
    repeat (3) @(negedge clk);
    bus_access(1'b0, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_IN)), '0, rd);
    check_equal("gpio in read", rd, pins);
    bus_access(1'b0, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_DIR)), '0, rd);
    check_equal("gpio dir read", rd, model_dir);
    bus_access(1'b0, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_OUT)), '0, rd);
    check_equal("gpio out read", rd, model_out);
  end
endtask

task automatic unmapped_slot_sequence();
  bus_word_t w;
  bus_word_t data;
  bus_word_t rd;
  for (int i = 0; i < UNMAPPED_ACCESSES; i++) begin
    w    = random_word();
    data = random_word();
    bus_access(w[12], 2'b11, slot_address(unmapped_slot(w[15:13]), w[11:0]), data, rd);
    check_equal("unmapped read", rd, 16'd0);
  end
  // Nothing else moved
  bus_access(1'b0, 2'b11, slot_address(SLOT_CONFIG, 12'(CFG_SAMPLE_RATE)), '0, rd);
  check_equal("config read", rd, model_rate);
  bus_access(1'b0, 2'b11, slot_address(SLOT_CONFIG, 12'(CFG_GAIN)), '0, rd);
  check_equal("config read", rd, model_gain);
  bus_access(1'b0, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_DIR)), '0, rd);
  check_equal("gpio dir read", rd, model_dir);
  bus_access(1'b0, 2'b11, slot_address(SLOT_GPIO, 12'(GPIO_OUT)), '0, rd);
  check_equal("gpio out read", rd, model_out);
  check_equal("gpio_oe_o", gpio_oe_o, model_dir);
  check_equal("mic_data_gain_o", mic_data_gain_o, model_gain);
endtask

`endif

// ==== dv/tb_system.sv ====
`timescale 1ns/1ps
`include "creator_config.svh"

module tb_system import bus_pkg::*; import periph_pkg::*; ();

  logic                      clk;
  logic                      reset_i;
  logic                      cyc_i;
  logic                      stb_i;
  logic                      we_i;
  bus_sel_t                  sel_i;
  bus_addr_t                 adr_i;
  bus_word_t                 dat_i;
  bus_word_t                 dat_o;
  logic                      ack_o;
  logic [`CR_GPIO_WIDTH-1:0] gpio_in_i;
  logic [`CR_GPIO_WIDTH-1:0] gpio_out_o;
  logic [`CR_GPIO_WIDTH-1:0] gpio_oe_o;
  bus_word_t                 mic_sample_rate_o;
  bus_word_t                 mic_data_gain_o;

  integer seed        = 32'h18c53bf1;
  int     error_count = 0;

  creator_system dut_i (
    .clk(clk), .reset_i(reset_i),
    .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .sel_i(sel_i),
    .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
    .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o),
    .mic_sample_rate_o(mic_sample_rate_o), .mic_data_gain_o(mic_data_gain_o)
  );

  // --------------------------------------------------
  // Checker, random source and bus master
  // --------------------------------------------------
  task automatic check_equal(input string name, input bus_word_t actual,
                             input bus_word_t expected);
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t ns: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic bus_word_t random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic bus_access(input logic we, input bus_sel_t sel, input bus_addr_t adr,
                            input bus_word_t wdata, output bus_word_t rdata);
    int waits;
    waits = 0;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    sel_i = sel;
    adr_i = adr;
    dat_i = wdata;
    do begin
      @(negedge clk);
      waits++;
      if (waits > 8) begin
        $display("No acknowledge from the bus after 8 cycles, address 0x%h", adr);
        $display("CHECKS FAILED");
        $fatal(1, "bus timeout");
      end
    end while (!ack_o);
    // Read data is valid in the ack cycle
    rdata = dat_o;
    check_equal("ack latency", bus_word_t'(waits), 16'd1);
    // Request still held over the next edge, no second ack allowed
    @(negedge clk);
    check_equal("ack_o pulse", bus_word_t'(ack_o), 16'd0);
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    // Strobe low for a full cycle before the next request
    @(negedge clk);
  endtask

  `include "tb_model.svh"

  // Reads and writes issued by all sequences
  localparam int ACCESS_COUNT = 8 + 2 * MIC_ROUNDS + 2 * SCRATCH_WRITES + 5 * GPIO_ROUNDS +
                                UNMAPPED_ACCESSES + 4;
  localparam int WATCHDOG_NS  = (ACCESS_COUNT * 20 + 200) * 4;

  // --------------------------------------------------
  // Clock, watchdog and main sequence
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog");
  end

  initial begin
    reset_i   = 1'b1;
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    we_i      = 1'b0;
    sel_i     = '0;
    adr_i     = '0;
    dat_i     = '0;
    gpio_in_i = '0;
    init_model();
    // Three rising edges in reset
    repeat (3) @(negedge clk);
    reset_i = 1'b0;
    verify_reset_state();
    mic_settings_sequence();
    scratch_ram_sequence();
    gpio_sequence();
    unmapped_slot_sequence();
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
+incdir+dv
source/bus_pkg.sv
source/periph_pkg.sv
source/wb_decoder.sv
source/config_regs.sv
source/gpio_port.sv
source/scratch_bram.sv
source/creator_system.sv
dv/tb_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the creator_system testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_system \
  -f compile.f \
  -o Vtb_system

./obj_dir/Vtb_system | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
